/* verilog/rn_pkg.sv */
package rn_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // instructions offered per group
  localparam int DISP_SIZE   = 2;
  localparam int NUM_LOGICAL = 32;
  localparam int NUM_PHYS    = 48;
  // write-back ports into the ready table
  localparam int WB_SIZE     = 2;
  // source operands per instruction
  localparam int NUM_RS      = 2;

  // IDs left over once every logical register holds one
  localparam int FLIST_SIZE  = NUM_PHYS - NUM_LOGICAL;
  localparam int FLIST_IDX_W = $clog2(FLIST_SIZE);

  // ----------------------------------------
  // index types
  // ----------------------------------------

  typedef logic [$clog2(NUM_LOGICAL)-1:0] lreg_t;
  // wide enough for a 64-entry physical file as well
  typedef logic [5:0] rnid_t;
  // index plus wrap bit
  typedef logic [FLIST_IDX_W:0] flist_ptr_t;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // x0 is hardwired and never renamed
  function automatic logic is_zero_reg(lreg_t idx);
    return idx == '0;
  endfunction

  // occupied entries between head and tail
  function automatic flist_ptr_t flist_count(flist_ptr_t head, flist_ptr_t tail);
    return tail - head;
  endfunction

endpackage

/* verilog/rn_freelist.sv */
module rn_freelist #(
  parameter int DISP_SIZE = rn_pkg::DISP_SIZE,
  parameter int NUM_PHYS  = rn_pkg::NUM_PHYS
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,

  // pop side, already qualified by fire
  input  logic          [DISP_SIZE-1:0]       i_alloc,
  output rn_pkg::rnid_t [DISP_SIZE-1:0]       o_alloc_rnid,
  output logic                                o_free_ok,

  // push side from the committer
  input  logic                                i_commit_valid,
  input  logic          [DISP_SIZE-1:0]       i_commit_rd_valid,
  input  rn_pkg::rnid_t [DISP_SIZE-1:0]       i_commit_old_rnid,

  input  logic                                i_flush
);

  // capacity is a power of two so the wrap bit works out
  localparam int FL_SIZE = NUM_PHYS - rn_pkg::NUM_LOGICAL;
  localparam int IDX_W   = $clog2(FL_SIZE);
  localparam int PTR_W   = IDX_W + 1;

  typedef logic [PTR_W-1:0] ptr_t;

  rn_pkg::rnid_t r_flist [FL_SIZE];

  ptr_t r_spec_head;
  ptr_t r_cmt_head;
  ptr_t r_tail;

  ptr_t                 w_free_cnt;
  ptr_t                 w_alloc_cnt;
  ptr_t                 w_push_cnt;
  ptr_t [DISP_SIZE-1:0] w_alloc_ptr;
  ptr_t [DISP_SIZE-1:0] w_push_ptr;
  logic [DISP_SIZE-1:0] w_push;

  assign w_push     = i_commit_rd_valid & {DISP_SIZE{i_commit_valid}};
  assign w_free_cnt = r_tail - r_spec_head;
  assign o_free_ok  = w_free_cnt >= ptr_t'(DISP_SIZE);

  // lower slot takes the earlier entry, idle slots take none
  always_comb begin
    w_alloc_cnt = '0;
    w_push_cnt  = '0;
    for (int s = 0; s < DISP_SIZE; s++) begin
      w_alloc_ptr[s] = r_spec_head + w_alloc_cnt;
      w_push_ptr[s]  = r_tail + w_push_cnt;
      w_alloc_cnt    = w_alloc_cnt + ptr_t'(i_alloc[s]);
      w_push_cnt     = w_push_cnt + ptr_t'(w_push[s]);
    end
  end

  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      o_alloc_rnid[s] = r_flist[w_alloc_ptr[s][IDX_W-1:0]];
    end
  end

  // ----------------------------------------
  // pointers and storage
  // ----------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_spec_head <= '0;
      r_cmt_head  <= '0;
      r_tail      <= ptr_t'(FL_SIZE);
      for (int i = 0; i < FL_SIZE; i++) begin
        r_flist[i] <= rn_pkg::rnid_t'(rn_pkg::NUM_LOGICAL + i);
      end
    end else begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (w_push[s]) begin
          r_flist[w_push_ptr[s][IDX_W-1:0]] <= i_commit_old_rnid[s];
        end
      end
      r_tail     <= r_tail + w_push_cnt;
      r_cmt_head <= r_cmt_head + w_push_cnt;
      // committed entries stay in place, so recovery is a pointer move
      if (i_flush) begin
        r_spec_head <= r_cmt_head + w_push_cnt;
      end else begin
        r_spec_head <= r_spec_head + w_alloc_cnt;
      end
    end
  end

  // rename must hold off when the list runs short
  a_no_underflow : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_alloc_cnt <= w_free_cnt);

  // commits retire only IDs that rename has already taken
  a_cmt_behind_spec : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_push_cnt <= ptr_t'(r_spec_head - r_cmt_head));

endmodule

/* verilog/rn_map.sv */
module rn_map #(
  parameter int DISP_SIZE = rn_pkg::DISP_SIZE
) (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,

  input  logic                                                 i_fire,
  // set only for slots that really allocate
  input  logic          [DISP_SIZE-1:0]                        i_slot_rd_valid,
  input  rn_pkg::lreg_t [DISP_SIZE-1:0]                        i_slot_rd_idx,
  input  rn_pkg::lreg_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    i_slot_rs_idx,
  input  rn_pkg::rnid_t [DISP_SIZE-1:0]                        i_alloc_rnid,
  output rn_pkg::rnid_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    o_rs_rnid,
  output rn_pkg::rnid_t [DISP_SIZE-1:0]                        o_old_rnid,

  input  logic                                                 i_commit_valid,
  input  logic          [DISP_SIZE-1:0]                        i_commit_rd_valid,
  input  rn_pkg::lreg_t [DISP_SIZE-1:0]                        i_commit_rd_idx,
  input  rn_pkg::rnid_t [DISP_SIZE-1:0]                        i_commit_new_rnid,

  input  logic                                                 i_flush
);

  rn_pkg::rnid_t r_spec_map    [rn_pkg::NUM_LOGICAL];
  rn_pkg::rnid_t r_cmt_map     [rn_pkg::NUM_LOGICAL];
  rn_pkg::rnid_t w_cmt_map_nxt [rn_pkg::NUM_LOGICAL];

  // ----------------------------------------
  // lookup with in-group bypass
  // ----------------------------------------

  // walk earlier slots in order so the latest writer wins
  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      for (int r = 0; r < rn_pkg::NUM_RS; r++) begin
        o_rs_rnid[s][r] = r_spec_map[i_slot_rs_idx[s][r]];
        for (int t = 0; t < s; t++) begin
          if (i_slot_rd_valid[t] && (i_slot_rd_idx[t] == i_slot_rs_idx[s][r])) begin
            o_rs_rnid[s][r] = i_alloc_rnid[t];
          end
        end
        if (rn_pkg::is_zero_reg(i_slot_rs_idx[s][r])) begin
          o_rs_rnid[s][r] = '0;
        end
      end

      // previous owner of the destination, freed when this slot commits
      o_old_rnid[s] = r_spec_map[i_slot_rd_idx[s]];
      for (int t = 0; t < s; t++) begin
        if (i_slot_rd_valid[t] && (i_slot_rd_idx[t] == i_slot_rd_idx[s])) begin
          o_old_rnid[s] = i_alloc_rnid[t];
        end
      end
      if (rn_pkg::is_zero_reg(i_slot_rd_idx[s])) begin
        o_old_rnid[s] = '0;
      end
    end
  end

  // commit map as it will be next cycle
  always_comb begin
    w_cmt_map_nxt = r_cmt_map;
    if (i_commit_valid) begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (i_commit_rd_valid[s]) begin
          w_cmt_map_nxt[i_commit_rd_idx[s]] = i_commit_new_rnid[s];
        end
      end
    end
  end

  // ----------------------------------------
  // table update
  // ----------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < rn_pkg::NUM_LOGICAL; i++) begin
        r_spec_map[i] <= rn_pkg::rnid_t'(i);
        r_cmt_map[i]  <= rn_pkg::rnid_t'(i);
      end
    end else begin
      r_cmt_map <= w_cmt_map_nxt;
      if (i_flush) begin
        // same-cycle commit already folded in
        r_spec_map <= w_cmt_map_nxt;
      end else if (i_fire) begin
        for (int s = 0; s < DISP_SIZE; s++) begin
          if (i_slot_rd_valid[s]) begin
            r_spec_map[i_slot_rd_idx[s]] <= i_alloc_rnid[s];
          end
        end
      end
    end
  end

  // the committer only retires destinations that were renamed
  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_cmt_chk
    a_cmt_not_x0 : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (i_commit_valid && i_commit_rd_valid[s]) |-> !rn_pkg::is_zero_reg(i_commit_rd_idx[s]));
  end

endmodule

/* verilog/rn_inflight.sv */
module rn_inflight #(
  parameter int DISP_SIZE = rn_pkg::DISP_SIZE,
  parameter int NUM_PHYS  = rn_pkg::NUM_PHYS,
  parameter int WB_SIZE   = rn_pkg::WB_SIZE
) (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,

  input  logic                                                 i_fire,
  input  logic          [DISP_SIZE-1:0]                        i_alloc,
  input  rn_pkg::rnid_t [DISP_SIZE-1:0]                        i_alloc_rnid,

  input  logic          [WB_SIZE-1:0]                          i_wb_valid,
  input  rn_pkg::rnid_t [WB_SIZE-1:0]                          i_wb_rnid,

  input  logic                                                 i_flush,

  input  rn_pkg::rnid_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    i_rs_rnid,
  output logic          [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    o_rs_ready
);

  // one bit per physical register, set means value available
  logic [NUM_PHYS-1:0] r_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else if (i_flush) begin
      r_ready <= '1;
    end else begin
      for (int w = 0; w < WB_SIZE; w++) begin
        if (i_wb_valid[w]) begin
          r_ready[i_wb_rnid[w]] <= 1'b1;
        end
      end
      if (i_fire) begin
        for (int s = 0; s < DISP_SIZE; s++) begin
          if (i_alloc[s]) begin
            r_ready[i_alloc_rnid[s]] <= 1'b0;
          end
        end
      end
    end
  end

  // table, then write-back bypass, then producers earlier in the group
  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      for (int r = 0; r < rn_pkg::NUM_RS; r++) begin
        o_rs_ready[s][r] = r_ready[i_rs_rnid[s][r]];
        for (int w = 0; w < WB_SIZE; w++) begin
          if (i_wb_valid[w] && (i_wb_rnid[w] == i_rs_rnid[s][r])) begin
            o_rs_ready[s][r] = 1'b1;
          end
        end
        for (int t = 0; t < s; t++) begin
          if (i_alloc[t] && (i_alloc_rnid[t] == i_rs_rnid[s][r])) begin
            o_rs_ready[s][r] = 1'b0;
          end
        end
      end
    end
  end

  // p0 backs x0 and is never produced by an execution unit
  for (genvar w = 0; w < WB_SIZE; w++) begin : g_wb_chk
    a_wb_not_p0 : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_wb_valid[w] |-> (i_wb_rnid[w] != '0));
  end

endmodule

/* verilog/rn_rename.sv */
module rn_rename #(
  parameter int DISP_SIZE = rn_pkg::DISP_SIZE,
  parameter int NUM_PHYS  = rn_pkg::NUM_PHYS,
  parameter int WB_SIZE   = rn_pkg::WB_SIZE
) (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,

  // front end group
  input  logic                                                 i_front_valid,
  output logic                                                 o_front_ready,
  input  logic          [DISP_SIZE-1:0]                        i_slot_valid,
  input  logic          [DISP_SIZE-1:0]                        i_slot_rd_valid,
  input  rn_pkg::lreg_t [DISP_SIZE-1:0]                        i_slot_rd_idx,
  input  logic          [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    i_slot_rs_valid,
  input  rn_pkg::lreg_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    i_slot_rs_idx,

  // write-back
  input  logic          [WB_SIZE-1:0]                          i_wb_valid,
  input  rn_pkg::rnid_t [WB_SIZE-1:0]                          i_wb_rnid,

  // commit
  input  logic                                                 i_commit_valid,
  input  logic          [DISP_SIZE-1:0]                        i_commit_rd_valid,
  input  rn_pkg::lreg_t [DISP_SIZE-1:0]                        i_commit_rd_idx,
  input  rn_pkg::rnid_t [DISP_SIZE-1:0]                        i_commit_new_rnid,
  input  rn_pkg::rnid_t [DISP_SIZE-1:0]                        i_commit_old_rnid,

  input  logic                                                 i_flush,

  // renamed group, one cycle after fire
  output logic                                                 o_rn_valid,
  output logic          [DISP_SIZE-1:0]                        o_slot_out_valid,
  output rn_pkg::rnid_t [DISP_SIZE-1:0]                        o_rn_rd_rnid,
  output rn_pkg::rnid_t [DISP_SIZE-1:0]                        o_rn_old_rnid,
  output rn_pkg::rnid_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    o_rn_rs_rnid,
  output logic          [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]    o_rn_rs_ready
);

  logic                                               w_free_ok;
  logic                                               w_fire;
  logic          [DISP_SIZE-1:0]                      w_alloc;
  logic          [DISP_SIZE-1:0]                      w_alloc_fire;
  rn_pkg::rnid_t [DISP_SIZE-1:0]                      w_alloc_rnid;
  rn_pkg::rnid_t [DISP_SIZE-1:0]                      w_old_rnid;
  rn_pkg::lreg_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]  w_rs_idx;
  rn_pkg::rnid_t [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]  w_rs_rnid;
  logic          [DISP_SIZE-1:0][rn_pkg::NUM_RS-1:0]  w_rs_ready;

  // ----------------------------------------
  // accept and allocation strobes
  // ----------------------------------------

  assign o_front_ready = w_free_ok & ~i_flush;
  assign w_fire        = i_front_valid & o_front_ready;

  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      w_alloc[s] = i_slot_valid[s] & i_slot_rd_valid[s] &
                   ~rn_pkg::is_zero_reg(i_slot_rd_idx[s]);
    end
  end

  // free list pops only when the group is taken
  assign w_alloc_fire = w_alloc & {DISP_SIZE{w_fire}};

  // unused sources look up x0, which reads p0 and ready
  always_comb begin
    for (int s = 0; s < DISP_SIZE; s++) begin
      for (int r = 0; r < rn_pkg::NUM_RS; r++) begin
        w_rs_idx[s][r] = (i_slot_valid[s] & i_slot_rs_valid[s][r]) ? i_slot_rs_idx[s][r] : '0;
      end
    end
  end

  // ----------------------------------------
  // sub-units
  // ----------------------------------------

  rn_freelist #(
    .DISP_SIZE (DISP_SIZE),
    .NUM_PHYS  (NUM_PHYS)
  ) u_freelist (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_alloc           (w_alloc_fire),
    .o_alloc_rnid      (w_alloc_rnid),
    .o_free_ok         (w_free_ok),
    .i_commit_valid    (i_commit_valid),
    .i_commit_rd_valid (i_commit_rd_valid),
    .i_commit_old_rnid (i_commit_old_rnid),
    .i_flush           (i_flush)
  );

  rn_map #(
    .DISP_SIZE (DISP_SIZE)
  ) u_map (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_fire            (w_fire),
    .i_slot_rd_valid   (w_alloc),
    .i_slot_rd_idx     (i_slot_rd_idx),
    .i_slot_rs_idx     (w_rs_idx),
    .i_alloc_rnid      (w_alloc_rnid),
    .o_rs_rnid         (w_rs_rnid),
    .o_old_rnid        (w_old_rnid),
    .i_commit_valid    (i_commit_valid),
    .i_commit_rd_valid (i_commit_rd_valid),
    .i_commit_rd_idx   (i_commit_rd_idx),
    .i_commit_new_rnid (i_commit_new_rnid),
    .i_flush           (i_flush)
  );

  rn_inflight #(
    .DISP_SIZE (DISP_SIZE),
    .NUM_PHYS  (NUM_PHYS),
    .WB_SIZE   (WB_SIZE)
  ) u_inflight (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_fire       (w_fire),
    .i_alloc      (w_alloc),
    .i_alloc_rnid (w_alloc_rnid),
    .i_wb_valid   (i_wb_valid),
    .i_wb_rnid    (i_wb_rnid),
    .i_flush      (i_flush),
    .i_rs_rnid    (w_rs_rnid),
    .o_rs_ready   (w_rs_ready)
  );

  // ----------------------------------------
  // output stage
  // ----------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rn_valid       <= 1'b0;
      o_slot_out_valid <= '0;
    end else begin
      o_rn_valid       <= w_fire;
      o_slot_out_valid <= i_slot_valid & {DISP_SIZE{w_fire}};
    end
  end

  // payload held between groups
  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      for (int s = 0; s < DISP_SIZE; s++) begin
        o_rn_rd_rnid[s]  <= w_alloc[s] ? w_alloc_rnid[s] : '0;
        o_rn_old_rnid[s] <= w_alloc[s] ? w_old_rnid[s] : '0;
      end
      o_rn_rs_rnid  <= w_rs_rnid;
      o_rn_rs_ready <= w_rs_ready;
    end
  end

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_reset_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  // release just after an edge, clear of the sampling point
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1;
    o_reset_n = 1'b1;
  end

endmodule

/* tb/tb_rename.sv */
module tb_rename;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int  DISP       = rn_pkg::DISP_SIZE;
  localparam int  NRS        = rn_pkg::NUM_RS;
  localparam int  WB         = rn_pkg::WB_SIZE;
  localparam time CLK_PERIOD = 40ns;
  localparam time DRIVE_DLY  = 5ns;
  // reset, then each test in turn, in cycles
  localparam int  TEST_CYCLES = 11 + 4 + 5 + 2 + 6 + 18 + 25;

  logic                               i_clk;
  logic                               i_reset_n;
  logic                               i_front_valid;
  logic                               o_front_ready;
  logic          [DISP-1:0]           i_slot_valid;
  logic          [DISP-1:0]           i_slot_rd_valid;
  rn_pkg::lreg_t [DISP-1:0]           i_slot_rd_idx;
  logic          [DISP-1:0][NRS-1:0]  i_slot_rs_valid;
  rn_pkg::lreg_t [DISP-1:0][NRS-1:0]  i_slot_rs_idx;
  logic          [WB-1:0]             i_wb_valid;
  rn_pkg::rnid_t [WB-1:0]             i_wb_rnid;
  logic                               i_commit_valid;
  logic          [DISP-1:0]           i_commit_rd_valid;
  rn_pkg::lreg_t [DISP-1:0]           i_commit_rd_idx;
  rn_pkg::rnid_t [DISP-1:0]           i_commit_new_rnid;
  rn_pkg::rnid_t [DISP-1:0]           i_commit_old_rnid;
  logic                               i_flush;
  logic                               o_rn_valid;
  logic          [DISP-1:0]           o_slot_out_valid;
  rn_pkg::rnid_t [DISP-1:0]           o_rn_rd_rnid;
  rn_pkg::rnid_t [DISP-1:0]           o_rn_old_rnid;
  rn_pkg::rnid_t [DISP-1:0][NRS-1:0]  o_rn_rs_rnid;
  logic          [DISP-1:0][NRS-1:0]  o_rn_rs_ready;

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  int spec_map [rn_pkg::NUM_LOGICAL];
  int cmt_map  [rn_pkg::NUM_LOGICAL];
  bit ready_m  [rn_pkg::NUM_PHYS];
  // front is the oldest uncommitted entry, spec_pos counts speculative pops
  int free_q[$];
  int spec_pos;
  // renamed destinations awaiting commit, oldest first
  int rec_rd[$];
  int rec_new[$];
  int rec_old[$];
  int n_checks;
  int n_errors;

  tb_clock_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (10)
  ) u_clk_gen (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  rn_rename #(
    .DISP_SIZE (rn_pkg::DISP_SIZE),
    .NUM_PHYS  (rn_pkg::NUM_PHYS),
    .WB_SIZE   (rn_pkg::WB_SIZE)
  ) dut0 (.*);

  task automatic check_eq(string what, int got, int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic void model_reset();
    for (int i = 0; i < rn_pkg::NUM_LOGICAL; i++) begin
      spec_map[i] = i;
      cmt_map[i]  = i;
    end
    foreach (ready_m[p]) begin
      ready_m[p] = 1'b1;
    end
    free_q.delete();
    for (int i = rn_pkg::NUM_LOGICAL; i < rn_pkg::NUM_PHYS; i++) begin
      free_q.push_back(i);
    end
    spec_pos = 0;
  endfunction

  function automatic int rand_reg();
    return 1 + ($urandom % (rn_pkg::NUM_LOGICAL - 1));
  endfunction

  task automatic set_slot(int s, bit valid, bit rd_v, int rd, bit rs0_v, int rs0,
                          bit rs1_v, int rs1);
    i_slot_valid[s]       = valid;
    i_slot_rd_valid[s]    = rd_v;
    i_slot_rd_idx[s]      = rn_pkg::lreg_t'(rd);
    i_slot_rs_valid[s][0] = rs0_v;
    i_slot_rs_idx[s][0]   = rn_pkg::lreg_t'(rs0);
    i_slot_rs_valid[s][1] = rs1_v;
    i_slot_rs_idx[s][1]   = rn_pkg::lreg_t'(rs1);
  endtask

  // offer the group for one cycle, predict the result, check it a cycle later
  task automatic send_group();
    int exp_rd  [DISP];
    int exp_old [DISP];
    int exp_rs  [DISP][NRS];
    bit exp_rdy [DISP][NRS];
    bit alloc   [DISP];
    bit fire;
    int k;
    int idx;
    fire = (free_q.size() - spec_pos >= DISP) && !i_flush;
    k = 0;
    for (int s = 0; s < DISP; s++) begin
      alloc[s]   = i_slot_valid[s] && i_slot_rd_valid[s] && (i_slot_rd_idx[s] != 0);
      exp_rd[s]  = (alloc[s] && fire) ? free_q[spec_pos + k] : 0;
      exp_old[s] = alloc[s] ? spec_map[i_slot_rd_idx[s]] : 0;
      for (int r = 0; r < NRS; r++) begin
        idx = (i_slot_valid[s] && i_slot_rs_valid[s][r]) ? int'(i_slot_rs_idx[s][r]) : 0;
        exp_rs[s][r]  = spec_map[idx];
        exp_rdy[s][r] = ready_m[exp_rs[s][r]];
        for (int w = 0; w < WB; w++) begin
          if (i_wb_valid[w] && (i_wb_rnid[w] == exp_rs[s][r])) begin
            exp_rdy[s][r] = 1'b1;
          end
        end
        for (int t = 0; t < s; t++) begin
          if (alloc[t] && (i_slot_rd_idx[t] == idx)) begin
            exp_rs[s][r]  = exp_rd[t];
            exp_rdy[s][r] = 1'b0;
          end
        end
        if (idx == 0) begin
          exp_rs[s][r]  = 0;
          exp_rdy[s][r] = 1'b1;
        end
      end
      for (int t = 0; t < s; t++) begin
        if (alloc[s] && alloc[t] && (i_slot_rd_idx[t] == i_slot_rd_idx[s])) begin
          exp_old[s] = exp_rd[t];
        end
      end
      k += alloc[s];
    end
    i_front_valid = 1'b1;
    @(negedge i_clk);
    check_eq("o_front_ready", o_front_ready, fire);
    @(posedge i_clk);
    #DRIVE_DLY;
    i_front_valid = 1'b0;
    // write-backs of the fire cycle land on the same edge
    for (int w = 0; w < WB; w++) begin
      if (i_wb_valid[w]) begin
        ready_m[i_wb_rnid[w]] = 1'b1;
      end
    end
    i_wb_valid = '0;
    check_eq("o_rn_valid", o_rn_valid, fire);
    if (fire) begin
      for (int s = 0; s < DISP; s++) begin
        check_eq($sformatf("slot %0d out valid", s), o_slot_out_valid[s], i_slot_valid[s]);
        check_eq($sformatf("slot %0d rd ID", s), o_rn_rd_rnid[s], exp_rd[s]);
        check_eq($sformatf("slot %0d old ID", s), o_rn_old_rnid[s], exp_old[s]);
        for (int r = 0; r < NRS; r++) begin
          check_eq($sformatf("slot %0d rs%0d ID", s, r), o_rn_rs_rnid[s][r], exp_rs[s][r]);
          check_eq($sformatf("slot %0d rs%0d ready", s, r), o_rn_rs_ready[s][r],
                   exp_rdy[s][r]);
        end
        if (alloc[s]) begin
          spec_map[i_slot_rd_idx[s]] = exp_rd[s];
          ready_m[exp_rd[s]]         = 1'b0;
          rec_rd.push_back(i_slot_rd_idx[s]);
          rec_new.push_back(exp_rd[s]);
          rec_old.push_back(exp_old[s]);
        end
      end
      spec_pos += k;
    end
  endtask

  task automatic rename_pair(int rd0, int rd1);
    set_slot(0, 1'b1, 1'b1, rd0, 1'b1, rand_reg(), 1'b1, rand_reg());
    set_slot(1, 1'b1, 1'b1, rd1, 1'b1, rand_reg(), 1'b1, rand_reg());
    send_group();
  endtask

  // retire the n oldest renamed destinations in one cycle
  task automatic commit_oldest(int n);
    i_commit_valid    = 1'b1;
    i_commit_rd_valid = '0;
    for (int s = 0; s < n; s++) begin
      i_commit_rd_valid[s] = 1'b1;
      i_commit_rd_idx[s]   = rn_pkg::lreg_t'(rec_rd[0]);
      i_commit_new_rnid[s] = rn_pkg::rnid_t'(rec_new[0]);
      i_commit_old_rnid[s] = rn_pkg::rnid_t'(rec_old[0]);
      cmt_map[rec_rd[0]] = rec_new[0];
      free_q.push_back(rec_old[0]);
      void'(free_q.pop_front());
      spec_pos--;
      void'(rec_rd.pop_front());
      void'(rec_new.pop_front());
      void'(rec_old.pop_front());
    end
    @(posedge i_clk);
    #DRIVE_DLY;
    i_commit_valid    = 1'b0;
    i_commit_rd_valid = '0;
  endtask

  task automatic commit_all();
    while (rec_rd.size() > 0) begin
      commit_oldest((rec_rd.size() < DISP) ? rec_rd.size() : DISP);
    end
  endtask

  task automatic write_back(int id);
    i_wb_valid[0] = 1'b1;
    i_wb_rnid[0]  = rn_pkg::rnid_t'(id);
    @(posedge i_clk);
    #DRIVE_DLY;
    i_wb_valid  = '0;
    ready_m[id] = 1'b1;
  endtask

  task automatic flush_pipe();
    i_flush = 1'b1;
    @(negedge i_clk);
    check_eq("o_front_ready during flush", o_front_ready, 0);
    @(posedge i_clk);
    #DRIVE_DLY;
    i_flush  = 1'b0;
    spec_map = cmt_map;
    spec_pos = 0;
    foreach (ready_m[p]) begin
      ready_m[p] = 1'b1;
    end
    rec_rd.delete();
    rec_new.delete();
    rec_old.delete();
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset_state();
    check_eq("o_rn_valid after reset", o_rn_valid, 0);
    check_eq("o_slot_out_valid after reset", o_slot_out_valid, 0);
    check_eq("o_front_ready after reset", o_front_ready, 1);
    repeat (4) begin
      set_slot(0, 1'b1, 1'b0, 0, 1'b1, rand_reg(), 1'b1, rand_reg());
      set_slot(1, 1'b1, 1'b0, 0, 1'b1, rand_reg(), 1'b0, 0);
      send_group();
      check_eq("identity map", o_rn_rs_rnid[0][0], i_slot_rs_idx[0][0]);
    end
  endtask

  task automatic test_alloc_order();
    rename_pair(rand_reg(), rand_reg());
    check_eq("first allocated ID", o_rn_rd_rnid[0], rn_pkg::NUM_LOGICAL);
    rename_pair(rand_reg(), rand_reg());
    rename_pair(rand_reg(), rand_reg());
    // x0 destination takes no ID
    set_slot(0, 1'b1, 1'b1, 0, 1'b1, rand_reg(), 1'b0, 0);
    set_slot(1, 1'b1, 1'b1, rand_reg(), 1'b0, 0, 1'b1, rand_reg());
    send_group();
    set_slot(0, 1'b1, 1'b1, rand_reg(), 1'b0, 0, 1'b0, 0);
    set_slot(1, 1'b0, 1'b1, rand_reg(), 1'b1, rand_reg(), 1'b0, 0);
    send_group();
  endtask

  task automatic test_dependencies();
    int a;
    int b;
    a = rand_reg();
    b = 1 + (a % (rn_pkg::NUM_LOGICAL - 1));
    set_slot(0, 1'b1, 1'b1, a, 1'b1, b, 1'b0, 0);
    set_slot(1, 1'b1, 1'b1, b, 1'b1, a, 1'b1, b);
    send_group();
    // both slots write a
    set_slot(0, 1'b1, 1'b1, a, 1'b1, a, 1'b0, 0);
    set_slot(1, 1'b1, 1'b1, a, 1'b1, a, 1'b0, 0);
    send_group();
  endtask

  task automatic test_readiness();
    int d;
    int p;
    d = rand_reg();
    set_slot(0, 1'b1, 1'b1, d, 1'b0, 0, 1'b0, 0);
    set_slot(1, 1'b0, 1'b0, 0, 1'b0, 0, 1'b0, 0);
    send_group();
    p = spec_map[d];
    set_slot(0, 1'b1, 1'b0, 0, 1'b1, d, 1'b0, 0);
    send_group();
    check_eq("source before write-back", o_rn_rs_ready[0][0], 0);
    i_wb_valid[1] = 1'b1;
    i_wb_rnid[1]  = rn_pkg::rnid_t'(p);
    send_group();
    check_eq("source with write-back bypass", o_rn_rs_ready[0][0], 1);
    set_slot(0, 1'b1, 1'b1, d, 1'b0, 0, 1'b0, 0);
    send_group();
    write_back(spec_map[d]);
    set_slot(0, 1'b1, 1'b0, 0, 1'b1, d, 1'b0, 0);
    send_group();
    check_eq("source after write-back", o_rn_rs_ready[0][0], 1);
  endtask

  task automatic test_backpressure();
    int e0;
    int e1;
    commit_all();
    for (int g = 0; g < rn_pkg::FLIST_SIZE / DISP; g++) begin
      rename_pair(rand_reg(), rand_reg());
    end
    check_eq("o_front_ready with list empty", o_front_ready, 0);
    rename_pair(rand_reg(), rand_reg());
    e0 = rec_old[0];
    e1 = rec_old[1];
    commit_oldest(2);
    check_eq("o_front_ready after commit", o_front_ready, 1);
    rename_pair(rand_reg(), rand_reg());
    check_eq("reused ID slot 0", o_rn_rd_rnid[0], e0);
    check_eq("reused ID slot 1", o_rn_rd_rnid[1], e1);
  endtask

  task automatic test_flush();
    commit_all();
    repeat (3) rename_pair(rand_reg(), rand_reg());
    commit_oldest(2);
    commit_oldest(2);
    repeat (2) rename_pair(rand_reg(), rand_reg());
    flush_pipe();
    // read back every logical register
    for (int g = 1; g < rn_pkg::NUM_LOGICAL; g += 4) begin
      set_slot(0, 1'b1, 1'b0, 0, 1'b1, g, 1'b1, g + 1);
      set_slot(1, 1'b1, 1'b0, 0, 1'b1, g + 2, 1'b1, (g + 3) % rn_pkg::NUM_LOGICAL);
      send_group();
    end
    rename_pair(rand_reg(), rand_reg());
  endtask

  // ----------------------------------------
  // run
  // ----------------------------------------

  initial begin
    i_front_valid     = 1'b0;
    i_slot_valid      = '0;
    i_slot_rd_valid   = '0;
    i_slot_rd_idx     = '0;
    i_slot_rs_valid   = '0;
    i_slot_rs_idx     = '0;
    i_wb_valid        = '0;
    i_wb_rnid         = '0;
    i_commit_valid    = 1'b0;
    i_commit_rd_valid = '0;
    i_commit_rd_idx   = '0;
    i_commit_new_rnid = '0;
    i_commit_old_rnid = '0;
    i_flush           = 1'b0;
    n_checks          = 0;
    n_errors          = 0;
    void'($urandom(32));
    model_reset();
    @(posedge i_reset_n);
    @(posedge i_clk);
    #DRIVE_DLY;
    test_reset_state();
    test_alloc_order();
    test_dependencies();
    test_readiness();
    test_backpressure();
    test_flush();
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // three times the expected run length
  initial begin
    #(3 * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

/* project.f */
verilog/rn_pkg.sv
verilog/rn_freelist.sv
verilog/rn_map.sv
verilog/rn_inflight.sv
verilog/rn_rename.sv
tb/tb_clock_gen.sv
tb/tb_rename.sv

/* Bender.yml */
package:
  name: rn_rename

sources:
  - verilog/rn_pkg.sv
  - verilog/rn_freelist.sv
  - verilog/rn_map.sv
  - verilog/rn_inflight.sv
  - verilog/rn_rename.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_rename.sv
